// File: design/rv_config.svh
/* core-wide widths and the trap opcode for the rv64i pipeline
   include wherever a width or the trap encoding is needed */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path width
`define XLEN 64

// integer register file size
`define NREGS 32

// register index width, log2 of NREGS
`define RIDX_W 5

// custom opcode that ends the run, code taken from x10
`define TRAP_OPCODE 7'h6b

`endif

// File: design/rv_pkg.sv
/* opcode and alu encodings plus the packets passed between pipeline stages
   import with rv_pkg::* in a module header */
`include "rv_config.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OP_IMM = 7'h13,
    OP     = 7'h33,
    LUI    = 7'h37,
    TRAP   = `TRAP_OPCODE
  } opcode_e;

  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    XOR    = 3'd2,
    OR     = 3'd3,
    AND    = 3'd4,
    PASS_B = 3'd5     // lui, result is opb
  } alu_op_e;

  // decode -> execute
  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    alu_op_e            alu_op;
    logic [`XLEN-1:0]   opa;
    logic [`XLEN-1:0]   opb;
    logic [`RIDX_W-1:0] rd;
    logic               rd_wen;
    logic               is_trap;
    logic               skip;
    logic [2:0]         trap_code;
  } dec_pkt_t;

  // execute -> commit
  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    logic [`XLEN-1:0]   result;
    logic [`RIDX_W-1:0] rd;
    logic               rd_wen;
    logic               is_trap;
    logic               skip;
    logic [2:0]         trap_code;
  } ex_pkt_t;

  // one record per retired instruction
  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    logic               wen;
    logic [`RIDX_W-1:0] wdest;
    logic [`XLEN-1:0]   wdata;
    logic               skip;
  } commit_t;

  // bypass source back into decode
  typedef struct packed {
    logic               valid;   // source will write rd
    logic [`RIDX_W-1:0] rd;
    logic [`XLEN-1:0]   data;
  } fwd_t;

endpackage

// File: design/rv_regfile.sv
/* integer register file, two async read ports and one write port
   x0 is never written so it always reads back zero */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
  input  logic               clk,
  input  logic               rst,
  input  logic [`RIDX_W-1:0] i_rs1,
  input  logic [`RIDX_W-1:0] i_rs2,
  output logic [`XLEN-1:0]   o_rs1_data,
  output logic [`XLEN-1:0]   o_rs2_data,
  input  logic               i_wen,
  input  logic [`RIDX_W-1:0] i_wdest,
  input  logic [`XLEN-1:0]   i_wdata
);

  logic [`XLEN-1:0] regs [`NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wdest != '0)) begin   // drop x0 writes
      regs[i_wdest] <= i_wdata;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

// File: design/rv_decode.sv
/* decode stage: classifies the instruction, builds immediates and operands
   with bypass from execute and commit, then registers the decoded packet */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decode import rv_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_valid,
  input  logic [`XLEN-1:0]   i_pc,
  input  logic [31:0]        i_inst,
  output logic [`RIDX_W-1:0] o_rs1,
  output logic [`RIDX_W-1:0] o_rs2,
  input  logic [`XLEN-1:0]   i_rs1_data,
  input  logic [`XLEN-1:0]   i_rs2_data,
  input  fwd_t               i_ex_fwd,
  input  fwd_t               i_cm_fwd,
  output dec_pkt_t           o_dec
);

  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic             is_op;
  logic             is_lui;
  logic             is_trap;
  logic             legal;
  alu_op_e          alu_op;
  dec_pkt_t         dec_d;

  // execute first, then commit, then the register file
  function automatic logic [`XLEN-1:0] pick_operand(
      input logic [`RIDX_W-1:0] idx,
      input logic [`XLEN-1:0]   rf_data,
      input fwd_t               ex_fwd,
      input fwd_t               cm_fwd);
    logic [`XLEN-1:0] val;
    if (idx == '0) val = '0;
    else if (ex_fwd.valid && ex_fwd.rd == idx) val = ex_fwd.data;
    else if (cm_fwd.valid && cm_fwd.rd == idx) val = cm_fwd.data;
    else val = rf_data;
    return val;
  endfunction

  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign is_op   = (i_inst[6:0] == OP);
  assign is_lui  = (i_inst[6:0] == LUI);
  assign is_trap = (i_inst[6:0] == TRAP);

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'h000};   // rv64 lui sign-extends

  // trap reads its code out of x10 through port 1
  assign o_rs1 = is_trap ? `RIDX_W'd10 : i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign rs1_val = pick_operand(o_rs1, i_rs1_data, i_ex_fwd, i_cm_fwd);
  assign rs2_val = pick_operand(o_rs2, i_rs2_data, i_ex_fwd, i_cm_fwd);

  always_comb begin
    alu_op = ADD;
    legal  = 1'b0;
    case (i_inst[6:0])
      OP_IMM: begin
        legal = 1'b1;
        case (funct3)
          3'b000:  alu_op = ADD;
          3'b100:  alu_op = XOR;
          3'b110:  alu_op = OR;
          3'b111:  alu_op = AND;
          default: legal = 1'b0;
        endcase
      end
      OP: begin
        legal = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op = ADD;
            3'b100:  alu_op = XOR;
            3'b110:  alu_op = OR;
            3'b111:  alu_op = AND;
            default: legal = 1'b0;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = SUB;
        end else begin
          legal = 1'b0;
        end
      end
      LUI: begin
        legal  = 1'b1;
        alu_op = PASS_B;
      end
      default: legal = 1'b0;   // trap and unknown opcodes write nothing
    endcase
  end

  always_comb begin
    dec_d.valid     = i_valid;
    dec_d.pc        = i_pc;
    dec_d.inst      = i_inst;
    dec_d.alu_op    = alu_op;
    dec_d.opa       = rs1_val;
    dec_d.opb       = is_op ? rs2_val : (is_lui ? imm_u : imm_i);
    dec_d.rd        = i_inst[11:7];
    dec_d.rd_wen    = legal;
    dec_d.is_trap   = is_trap;
    dec_d.skip      = ~legal & ~is_trap;
    dec_d.trap_code = is_trap ? rs1_val[2:0] : 3'd0;
  end

  always_ff @(posedge clk) begin
    o_dec <= dec_d;
    if (rst) o_dec.valid <= 1'b0;
  end

endmodule

// File: design/rv_execute.sv
/* execute stage: alu on the decoded operands, result bypassed to decode
   and registered with the control fields for commit */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_execute import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  dec_pkt_t i_dec,
  output ex_pkt_t  o_ex,
  output fwd_t     o_fwd
);

  logic [`XLEN-1:0] result;
  ex_pkt_t          ex_d;

  always_comb begin
    case (i_dec.alu_op)
      ADD:     result = i_dec.opa + i_dec.opb;
      SUB:     result = i_dec.opa - i_dec.opb;
      XOR:     result = i_dec.opa ^ i_dec.opb;
      OR:      result = i_dec.opa | i_dec.opb;
      AND:     result = i_dec.opa & i_dec.opb;
      PASS_B:  result = i_dec.opb;
      default: result = i_dec.opb;
    endcase
  end

  assign o_fwd.valid = i_dec.valid & i_dec.rd_wen;
  assign o_fwd.rd    = i_dec.rd;
  assign o_fwd.data  = result;

  always_comb begin
    ex_d.valid     = i_dec.valid;
    ex_d.pc        = i_dec.pc;
    ex_d.inst      = i_dec.inst;
    ex_d.result    = result;
    ex_d.rd        = i_dec.rd;
    ex_d.rd_wen    = i_dec.rd_wen;
    ex_d.is_trap   = i_dec.is_trap;
    ex_d.skip      = i_dec.skip;
    ex_d.trap_code = i_dec.trap_code;
  end

  always_ff @(posedge clk) begin
    o_ex <= ex_d;
    if (rst) o_ex.valid <= 1'b0;
  end

endmodule

// File: design/rv_commit.sv
/* commit stage: register write-back, retired-instruction record, trap halt
   and the cycle and instruction counters compared against the reference model */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_commit import rv_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  ex_pkt_t            i_ex,
  output logic               o_wen,
  output logic [`RIDX_W-1:0] o_wdest,
  output logic [`XLEN-1:0]   o_wdata,
  output fwd_t               o_fwd,
  output commit_t            o_commit,
  output logic               o_halt,
  output logic [2:0]         o_trap_code,
  output logic [`XLEN-1:0]   o_cycle_cnt,
  output logic [`XLEN-1:0]   o_instr_cnt
);

  logic    retire;
  commit_t cm_d;

  assign retire  = i_ex.valid & ~o_halt;   // nothing retires once halted
  assign o_wen   = retire & i_ex.rd_wen;
  assign o_wdest = i_ex.rd;
  assign o_wdata = i_ex.result;

  assign o_fwd.valid = o_wen;
  assign o_fwd.rd    = i_ex.rd;
  assign o_fwd.data  = i_ex.result;

  always_comb begin
    cm_d.valid = retire;
    cm_d.pc    = i_ex.pc;
    cm_d.inst  = i_ex.inst;
    cm_d.wen   = o_wen;
    cm_d.wdest = o_wen ? i_ex.rd : '0;       // dest only meaningful with wen
    cm_d.wdata = o_wen ? i_ex.result : '0;
    cm_d.skip  = retire & i_ex.skip;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_commit <= '0;
    end else begin
      o_commit <= cm_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_halt      <= 1'b0;
      o_trap_code <= 3'd0;
      o_cycle_cnt <= '0;
      o_instr_cnt <= '0;
    end else if (!o_halt) begin
      o_cycle_cnt <= o_cycle_cnt + 1'b1;
      if (retire) o_instr_cnt <= o_instr_cnt + 1'b1;   // skips and trap count too
      if (retire && i_ex.is_trap) begin
        o_halt      <= 1'b1;
        o_trap_code <= i_ex.trap_code;
      end
    end
  end

endmodule

// File: design/rv_core_top.sv
/* rv64i subset core: decode, execute and commit around a 32-entry register file
   one instruction per i_valid strobe, retirements come out on o_commit */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_top import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [31:0]      i_inst,
  output commit_t          o_commit,
  output logic             o_halt,
  output logic [2:0]       o_trap_code,
  output logic [`XLEN-1:0] o_cycle_cnt,
  output logic [`XLEN-1:0] o_instr_cnt
);

  logic [`RIDX_W-1:0] rs1;
  logic [`RIDX_W-1:0] rs2;
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;
  logic               wen;
  logic [`RIDX_W-1:0] wdest;
  logic [`XLEN-1:0]   wdata;
  dec_pkt_t           dec;
  ex_pkt_t            ex;
  fwd_t               ex_fwd;
  fwd_t               cm_fwd;

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (wen),
    .i_wdest    (wdest),
    .i_wdata    (wdata)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_pc       (i_pc),
    .i_inst     (i_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_ex_fwd   (ex_fwd),
    .i_cm_fwd   (cm_fwd),
    .o_dec      (dec)
  );

  rv_execute u_execute (
    .clk   (clk),
    .rst   (rst),
    .i_dec (dec),
    .o_ex  (ex),
    .o_fwd (ex_fwd)
  );

  rv_commit u_commit (
    .clk         (clk),
    .rst         (rst),
    .i_ex        (ex),
    .o_wen       (wen),
    .o_wdest     (wdest),
    .o_wdata     (wdata),
    .o_fwd       (cm_fwd),
    .o_commit    (o_commit),
    .o_halt      (o_halt),
    .o_trap_code (o_trap_code),
    .o_cycle_cnt (o_cycle_cnt),
    .o_instr_cnt (o_instr_cnt)
  );

endmodule

// File: tests/rv_core_assertions.sv
/* concurrent checks on the core's commit, halt and counter ports
   bound to rv_core_top from the testbench */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_assertions import rv_pkg::*; (
  input logic             clk,
  input logic             rst,
  input commit_t          i_commit,
  input logic             i_halt,
  input logic [`XLEN-1:0] i_instr_cnt
);

  int unsigned fail_cnt = 0;

  // trap itself commits on the edge that raises halt
  a_no_commit_halted: assert property (@(posedge clk) disable iff (rst)
      (i_halt && $past(i_halt)) |-> !i_commit.valid)
    else begin
      $error("commit record valid while halted");
      fail_cnt++;
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) i_halt |=> i_halt)
    else begin
      $error("halt dropped before reset");
      fail_cnt++;
    end

  a_wdest_clear: assert property (@(posedge clk) disable iff (rst)
      !i_commit.wen |-> (i_commit.wdest == '0))
    else begin
      $error("commit wdest nonzero without wen");
      fail_cnt++;
    end

  a_instr_cnt_mono: assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |-> (i_instr_cnt >= $past(i_instr_cnt)))
    else begin
      $error("instruction counter went backwards");
      fail_cnt++;
    end

endmodule

// File: tests/rv_core_tb.sv
/* testbench for the rv64i subset core, drives a table of instructions
   and checks every commit record, the halt, the trap code and the counters */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int SAMPLE_DELAY = 1;   // strobe driven after an edge is sampled at the next one
  localparam int COMMIT_LAT   = 2;   // sampling edge to commit record edge
  localparam logic [31:0] TRAP_INST = {25'd0, `TRAP_OPCODE};

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    logic [3:0]         gap;     // idle cycles before the strobe
    logic               wen;
    logic [`RIDX_W-1:0] wdest;
    logic [`XLEN-1:0]   wdata;
    logic               skip;
  } stim_t;

  logic             clk;
  logic             rst;
  logic             i_valid;
  logic [`XLEN-1:0] i_pc;
  logic [31:0]      i_inst;
  commit_t          o_commit;
  logic             o_halt;
  logic [2:0]       o_trap_code;
  logic [`XLEN-1:0] o_cycle_cnt;
  logic [`XLEN-1:0] o_instr_cnt;

  stim_t       stim_q[$];
  int unsigned drive_cyc[$];
  int unsigned cyc = 0;
  int unsigned errors = 0;
  int unsigned seen = 0;
  int unsigned exp_commits = 0;
  int unsigned timeout_limit = 1000;
  bit          trap_added = 1'b0;

  rv_core_top uut (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_pc        (i_pc),
    .i_inst      (i_inst),
    .o_commit    (o_commit),
    .o_halt      (o_halt),
    .o_trap_code (o_trap_code),
    .o_cycle_cnt (o_cycle_cnt),
    .o_instr_cnt (o_instr_cnt)
  );

  bind rv_core_top rv_core_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .i_commit    (o_commit),
    .i_halt      (o_halt),
    .i_instr_cnt (o_instr_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  task automatic add_entry(input logic [31:0] inst, input int gap, input logic wen,
                           input logic [4:0] wdest, input logic [63:0] wdata,
                           input logic skip);
    stim_t e;
    e.pc    = 64'h1000 + 64'(4 * stim_q.size());
    e.inst  = inst;
    e.gap   = gap[3:0];
    e.wen   = wen;
    e.wdest = wdest;
    e.wdata = wdata;
    e.skip  = skip;
    stim_q.push_back(e);
    if (!trap_added) exp_commits++;   // nothing behind the trap retires
    if (inst[6:0] == `TRAP_OPCODE) trap_added = 1'b1;
  endtask

  task automatic build_table();
    add_entry(enc_i(3'b000, 5'd1, 5'd0, 12'd5), 0, 1'b1, 5'd1, 64'd5, 1'b0);
    add_entry(enc_i(3'b000, 5'd2, 5'd0, 12'hffd), 0, 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd, 1'b0);
    add_entry(enc_i(3'b100, 5'd3, 5'd1, 12'h00f), 0, 1'b1, 5'd3, 64'h0a, 1'b0);   // x1 via commit
    add_entry(enc_i(3'b110, 5'd4, 5'd3, 12'h120), 0, 1'b1, 5'd4, 64'h12a, 1'b0);  // x3 via execute
    add_entry(enc_i(3'b111, 5'd5, 5'd2, 12'h6a5), 0, 1'b1, 5'd5, 64'h6a5, 1'b0);
    add_entry(enc_u(5'd6, 20'h12345), 1, 1'b1, 5'd6, 64'h1234_5000, 1'b0);
    add_entry(enc_u(5'd7, 20'h80000), 0, 1'b1, 5'd7, 64'hffff_ffff_8000_0000, 1'b0);
    add_entry(enc_r(7'h00, 3'b000, 5'd8, 5'd1, 5'd2), 2, 1'b1, 5'd8, 64'd2, 1'b0);
    add_entry(enc_r(7'h20, 3'b000, 5'd9, 5'd8, 5'd1), 0, 1'b1, 5'd9,
              64'hffff_ffff_ffff_fffd, 1'b0);
    add_entry(enc_r(7'h00, 3'b100, 5'd11, 5'd9, 5'd8), 0, 1'b1, 5'd11,
              64'hffff_ffff_ffff_ffff, 1'b0);   // both bypass paths at once
    add_entry(enc_r(7'h00, 3'b111, 5'd12, 5'd11, 5'd6), 0, 1'b1, 5'd12, 64'h1234_5000, 1'b0);
    add_entry(enc_r(7'h00, 3'b110, 5'd13, 5'd12, 5'd3), 0, 1'b1, 5'd13, 64'h1234_500a, 1'b0);
    add_entry(enc_i(3'b000, 5'd0, 5'd1, 12'd7), 0, 1'b1, 5'd0, 64'd12, 1'b0);    // x0 write
    add_entry(enc_r(7'h00, 3'b000, 5'd14, 5'd0, 5'd1), 0, 1'b1, 5'd14, 64'd5, 1'b0);
    add_entry({12'h000, 5'd1, 3'b000, 5'd9, 7'h0b}, 2, 1'b0, 5'd0, 64'd0, 1'b1);  // unknown
    add_entry(enc_i(3'b000, 5'd10, 5'd0, 12'd5), 3, 1'b1, 5'd10, 64'd5, 1'b0);
    add_entry(TRAP_INST, 0, 1'b0, 5'd0, 64'd0, 1'b0);
    add_entry(enc_i(3'b000, 5'd15, 5'd0, 12'd1), 0, 1'b1, 5'd15, 64'd1, 1'b0);
    add_entry(enc_r(7'h00, 3'b000, 5'd1, 5'd1, 5'd1), 0, 1'b1, 5'd1, 64'd10, 1'b0);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    i_valid <= 1'b0;
    i_inst  <= '0;
  endtask

  task automatic drive_entry(input stim_t e);
    @(posedge clk);
    i_valid <= 1'b1;
    i_pc    <= e.pc;
    i_inst  <= e.inst;
    drive_cyc.push_back(cyc);
  endtask

  // commit monitor, records are matched to the table in order
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst && o_commit.valid) begin
      if (seen >= exp_commits) begin
        $display("commit of pc %h at %0t came after the trap had retired", o_commit.pc, $time);
        errors++;
      end else begin
        check_value("o_commit.pc", o_commit.pc, stim_q[seen].pc);
        check_value("o_commit.inst", o_commit.inst, stim_q[seen].inst);
        check_value("o_commit.wen", o_commit.wen, stim_q[seen].wen);
        check_value("o_commit.wdest", o_commit.wdest, stim_q[seen].wdest);
        check_value("o_commit.wdata", o_commit.wdata, stim_q[seen].wdata);
        check_value("o_commit.skip", o_commit.skip, stim_q[seen].skip);
        // record seen one edge after it registers
        check_value("commit cycle", cyc, drive_cyc[seen] + SAMPLE_DELAY + COMMIT_LAT + 1);
        seen <= seen + 1;
      end
    end
  end

  initial begin
    @(posedge clk);
    while (cyc < timeout_limit) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d commits seen", cyc, seen, exp_commits);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int unsigned rst_cyc;
    rst     = 1'b1;
    i_valid = 1'b0;
    i_pc    = '0;
    i_inst  = '0;
    build_table();
    timeout_limit = stim_q.size() * 3 + 20;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    rst_cyc = cyc;   // last edge that still sees reset
    foreach (stim_q[i]) begin
      repeat (stim_q[i].gap) drive_idle();
      drive_entry(stim_q[i]);
    end
    drive_idle();
    while (!(o_halt && seen == exp_commits)) @(posedge clk);
    repeat (COMMIT_LAT + 2) @(posedge clk);   // room for stray commits behind the trap
    // counts from the edge after reset up to the trap's commit edge
    check_value("o_cycle_cnt", o_cycle_cnt,
                drive_cyc[exp_commits - 1] + SAMPLE_DELAY + COMMIT_LAT - rst_cyc);
    check_value("o_halt", o_halt, 1);
    check_value("o_trap_code", o_trap_code, 5);
    check_value("o_instr_cnt", o_instr_cnt, exp_commits);
    if (uut.u_assertions.fail_cnt != 0) begin
      $display("%0d concurrent assertion failures", uut.u_assertions.fail_cnt);
      errors += uut.u_assertions.fail_cnt;
    end
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_commit.sv
design/rv_core_top.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the core and its testbench with verilator, then runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f vlog.f -o rv_core_sim

status=0
output=$(./obj_dir/rv_core_sim) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
